/* rtl/ifu_cfg.svh */
// fetch unit config macros: address width, instruction width, pc reset address
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// instruction address width in bits
`define IFU_ADDR_W 32

// instruction word width in bits
`define IFU_INST_W 32

// first fetch address after reset
`define IFU_PC_RESET 32'h0000_1000

// wishbone byte lanes follow the instruction width
`define IFU_SEL_W (`IFU_INST_W / 8)

`endif

/* rtl/ifu_pkg.sv */
// ifu_pkg: redirect, if/id and wishbone structs, fetch fsm state enum
`default_nettype none

`include "ifu_cfg.svh"

package ifu_pkg;

    // jump request from execute
    typedef struct packed {
        logic                   valid;  // take the jump this cycle
        logic [`IFU_ADDR_W-1:0] addr;   // jump target
    } redirect_t;

    // word handed from fetch to decode
    typedef struct packed {
        logic                   valid;
        logic [`IFU_INST_W-1:0] inst;       // raw instruction
        logic [`IFU_ADDR_W-1:0] inst_addr;  // its address
    } if_id_t;

    // wishbone master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;   // always read here
        logic [`IFU_ADDR_W-1:0] adr;
        logic [`IFU_SEL_W-1:0]  sel;
    } wb_m2s_t;

    // wishbone slave to master
    typedef struct packed {
        logic                   ack;
        logic [`IFU_INST_W-1:0] dat;
    } wb_s2m_t;

    // fetch fsm: idle -> bus cycle -> word waiting for if/id
    typedef enum logic [1:0] {
        FS_IDLE = 2'd0,
        FS_BUS  = 2'd1,
        FS_RESP = 2'd2
    } fetch_state_e;

endpackage

`default_nettype wire

/* rtl/ifu_pipe.sv */
// ifu_pipe: if/id pipeline register with flush, hold and valid
`timescale 1ns/1ps
`default_nettype none

module ifu_pipe (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire logic             flush_i,  // clears valid, beats hold
    input  wire logic             hold_i,   // decode stall
    input  wire ifu_pkg::if_id_t  in_i,
    output logic                  full_o,   // valid contents
    output ifu_pkg::if_id_t       out_o
);

    ifu_pkg::if_id_t pipe_q;
    logic            freeze;

    // stalled with something in it, keep it
    // an empty register may still load under hold
    assign freeze = hold_i && pipe_q.valid;

    // valid bit, the only control state
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            pipe_q.valid <= 1'b0;
        end else if (!freeze) begin
            pipe_q.valid <= in_i.valid;  // bubble when no word offered
        end
    end

    // payload, no reset and no flush
    always_ff @(posedge clk) begin
        if (!freeze) begin
            pipe_q.inst      <= in_i.inst;
            pipe_q.inst_addr <= in_i.inst_addr;
        end
    end

    assign full_o = pipe_q.valid;
    assign out_o  = pipe_q;

endmodule

`default_nettype wire

/* rtl/ifu_ifetch.sv */
// ifu_ifetch: pc register, next-pc select, accept logic and if/id register instance
`timescale 1ns/1ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_ifetch (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire ifu_pkg::redirect_t     redirect_i,     // jump from execute
    input  wire logic                   hold_i,         // decode stall
    input  wire ifu_pkg::if_id_t        fetch_rsp_i,    // word from bus master
    output logic                        fetch_ready_o,  // if/id can take a word
    output logic [`IFU_ADDR_W-1:0]      pc_o,           // address to fetch
    output ifu_pkg::if_id_t             if_id_o         // to decode
);

    logic [`IFU_ADDR_W-1:0] pc_q;
    logic [`IFU_ADDR_W-1:0] pc_d;
    logic                   pipe_full;  // if/id holds a valid word
    logic                   accept;     // response written into if/id this cycle

    // word moves when if/id is empty or decode is not stalled
    assign fetch_ready_o = !pipe_full || !hold_i;
    assign accept        = fetch_rsp_i.valid && fetch_ready_o;

    // next pc: jump wins, then step past an accepted word
    always_comb begin
        if (redirect_i.valid) begin
            pc_d = redirect_i.addr;
        end else if (accept) begin
            pc_d = pc_q + `IFU_ADDR_W'(4);  // next sequential word
        end else begin
            pc_d = pc_q;  // hold while bus busy or if/id blocked
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `IFU_PC_RESET;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // if/id register, a jump always flushes it
    ifu_pipe u_ifu_pipe (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (redirect_i.valid),
        .hold_i  (hold_i),
        .in_i    (fetch_rsp_i),
        .full_o  (pipe_full),
        .out_o   (if_id_o)
    );

endmodule

`default_nettype wire

/* rtl/ifu_wb_fetch.sv */
// ifu_wb_fetch: wishbone classic fetch master fsm with stale-word discard
`timescale 1ns/1ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_wb_fetch (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic [`IFU_ADDR_W-1:0] pc_i,           // current pc
    input  wire ifu_pkg::redirect_t     redirect_i,
    input  wire logic                   fetch_ready_i,  // if/id takes the word
    input  wire ifu_pkg::wb_s2m_t       wb_i,
    output ifu_pkg::wb_m2s_t            wb_o,
    output ifu_pkg::if_id_t             fetch_rsp_o
);

    ifu_pkg::fetch_state_e  state_q;
    ifu_pkg::fetch_state_e  state_d;
    logic                   stale_q;  // word in flight belongs to the old stream
    logic                   stale_d;
    logic                   drop;     // discard the current word
    logic [`IFU_ADDR_W-1:0] adr_q;    // address of the word in flight
    logic [`IFU_INST_W-1:0] dat_q;    // captured read data

    // old stream if the jump came now or earlier in this cycle
    assign drop = stale_q || redirect_i.valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ifu_pkg::FS_IDLE: begin
                // pc changes on this edge under a jump, so wait one more cycle
                if (!redirect_i.valid) begin
                    state_d = ifu_pkg::FS_BUS;
                end
            end
            ifu_pkg::FS_BUS: begin
                // cycle is never aborted, only its data thrown away
                if (wb_i.ack) begin
                    state_d = drop ? ifu_pkg::FS_IDLE : ifu_pkg::FS_RESP;
                end
            end
            ifu_pkg::FS_RESP: begin
                if (drop || fetch_ready_i) begin
                    state_d = ifu_pkg::FS_IDLE;  // consumed or stale
                end
            end
            default: begin
                state_d = ifu_pkg::FS_IDLE;
            end
        endcase
    end

    // stale holds until the word is gone, cleared on return to idle
    always_comb begin
        if (state_d == ifu_pkg::FS_IDLE) begin
            stale_d = 1'b0;
        end else if (state_q != ifu_pkg::FS_IDLE) begin
            stale_d = drop;
        end else begin
            stale_d = 1'b0;  // fresh cycle starting
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ifu_pkg::FS_IDLE;
            stale_q <= 1'b0;
        end else begin
            state_q <= state_d;
            stale_q <= stale_d;
        end
    end

    // latch pc on the way out of idle
    always_ff @(posedge clk) begin
        if (state_q == ifu_pkg::FS_IDLE) begin
            adr_q <= pc_i;
        end
    end

    // grab data on ack
    always_ff @(posedge clk) begin
        if (state_q == ifu_pkg::FS_BUS && wb_i.ack) begin
            dat_q <= wb_i.dat;
        end
    end

    // bus outputs straight from state, stable through the cycle
    always_comb begin
        wb_o.cyc = (state_q == ifu_pkg::FS_BUS);
        wb_o.stb = (state_q == ifu_pkg::FS_BUS);
        wb_o.we  = 1'b0;              // read only
        wb_o.adr = adr_q;
        wb_o.sel = '1;                // full word
    end

    // word offered until if/id takes it
    // a stale word goes from bus straight back to idle, never to resp
    always_comb begin
        fetch_rsp_o.valid     = (state_q == ifu_pkg::FS_RESP);
        fetch_rsp_o.inst      = dat_q;
        fetch_rsp_o.inst_addr = adr_q;
    end

endmodule

`default_nettype wire

/* rtl/ifu_top.sv */
// ifu_top: fetch unit top, pc/if-id block and wishbone fetch master
`timescale 1ns/1ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_top (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire ifu_pkg::redirect_t  redirect_i,  // from execute
    input  wire logic                hold_i,      // from decode
    input  wire ifu_pkg::wb_s2m_t    wb_i,        // from memory
    output ifu_pkg::wb_m2s_t         wb_o,        // to memory
    output ifu_pkg::if_id_t          if_id_o      // to decode
);

    ifu_pkg::if_id_t        fetch_rsp;    // word from bus master
    logic                   fetch_ready;  // if/id can take it
    logic [`IFU_ADDR_W-1:0] pc;

    // pc and if/id register
    ifu_ifetch u_ifu_ifetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .redirect_i    (redirect_i),
        .hold_i        (hold_i),
        .fetch_rsp_i   (fetch_rsp),
        .fetch_ready_o (fetch_ready),
        .pc_o          (pc),
        .if_id_o       (if_id_o)
    );

    // wishbone side, one word in flight
    ifu_wb_fetch u_ifu_wb_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .pc_i          (pc),
        .redirect_i    (redirect_i),
        .fetch_ready_i (fetch_ready),
        .wb_i          (wb_i),
        .wb_o          (wb_o),
        .fetch_rsp_o   (fetch_rsp)
    );

endmodule

`default_nettype wire

/* test/ifu_imem_model.sv */
// ifu_imem_model: wishbone classic slave memory with random wait states and computed data
`timescale 1ns/1ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_imem_model (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire ifu_pkg::wb_m2s_t  wb_i,   // request from the fetch master
    output ifu_pkg::wb_s2m_t       wb_o    // ack and read data
);

    localparam logic [`IFU_INST_W-1:0] data_key = 32'h13A5_0000;  // contents = address ^ key

    integer     seed = 20524;  // fixed seed, same wait pattern every run
    logic [1:0] wait_q;        // wait states for the current request
    logic [1:0] count_q;       // cycles stb has been high so far
    logic       hit;           // ack this cycle

    assign hit = wb_i.cyc && wb_i.stb && (count_q == wait_q);

    // new wait count drawn for every request, 0 to 3 cycles
    always @(posedge clk) begin
        if (reset_i) begin
            count_q <= 2'd0;
            wait_q  <= 2'($random(seed));
        end else if (hit) begin
            count_q <= 2'd0;
            wait_q  <= 2'($random(seed));  // next request
        end else if (wb_i.cyc && wb_i.stb) begin
            count_q <= count_q + 2'd1;
        end
    end

    // zero wait states means ack in the stb cycle
    always_comb begin
        wb_o.ack = hit;
        wb_o.dat = wb_i.adr ^ data_key;  // no storage, data from the address
    end

endmodule

`default_nettype wire

/* test/ifu_checker.sv */
// ifu_checker: concurrent assertions on wishbone form and if/id hold, bound into ifu_top
`timescale 1ns/1ps
`default_nettype none

module ifu_checker (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire ifu_pkg::redirect_t  redirect_i,
    input  wire logic                hold_i,
    input  wire ifu_pkg::wb_m2s_t    wb_m2s_i,
    input  wire ifu_pkg::wb_s2m_t    wb_s2m_i,
    input  wire ifu_pkg::if_id_t     if_id_i
);

    // no strobe outside a bus cycle
    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset_i)
        wb_m2s_i.stb |-> wb_m2s_i.cyc)
        else $error("wishbone stb high while cyc is low");

    // address may only move once the slave has acked
    adr_held: assert property (@(posedge clk) disable iff (reset_i)
        (wb_m2s_i.stb && !wb_s2m_i.ack) |=> $stable(wb_m2s_i.adr))
        else $error("wishbone adr changed before ack");

    // instruction fetches are whole words
    adr_aligned: assert property (@(posedge clk) disable iff (reset_i)
        wb_m2s_i.stb |-> (wb_m2s_i.adr[1:0] == 2'b00))
        else $error("wishbone adr not word aligned");

    // stalled decode sees a frozen if/id, a jump may still flush it
    if_id_frozen: assert property (@(posedge clk) disable iff (reset_i)
        (hold_i && if_id_i.valid && !redirect_i.valid) |=> $stable(if_id_i))
        else $error("if_id_o changed while hold_i was high");

endmodule

bind ifu_top ifu_checker u_ifu_checker (
    .clk        (clk),
    .reset_i    (reset_i),
    .redirect_i (redirect_i),
    .hold_i     (hold_i),
    .wb_m2s_i   (wb_o),
    .wb_s2m_i   (wb_i),
    .if_id_i    (if_id_o)
);

`default_nettype wire

/* test/ifu_tb.sv */
// ifu_tb: clock, reset, stimulus table, bus monitor and compare tasks for ifu_top
`timescale 1ns/1ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_tb;

    localparam int clk_half   = 10;   // 20 ns period
    localparam int drive_dly  = 2;    // inputs move this long after the rising edge
    localparam int wait_limit = 200;  // cycles allowed for one valid output
    localparam int num_rows   = 12;
    localparam logic [`IFU_INST_W-1:0] data_key = 32'h13A5_0000;

    typedef enum logic [1:0] {
        ACT_RUN,       // take n words with decode running
        ACT_HOLD,      // stall decode n cycles on a valid word
        ACT_JUMP,      // one redirect pulse
        ACT_HOLD_JUMP  // stall n cycles, then jump with the stall still on
    } action_e;

    typedef struct packed {
        action_e                act;
        logic [15:0]            count;     // words or cycles
        logic [`IFU_ADDR_W-1:0] addr;      // jump target
        logic [`IFU_ADDR_W-1:0] exp_addr;  // address of the next valid output
    } row_t;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    logic               hold;
    ifu_pkg::redirect_t redirect;
    ifu_pkg::wb_m2s_t   wb_req;
    ifu_pkg::wb_s2m_t   wb_rsp;
    ifu_pkg::if_id_t    if_id;
    row_t               rows [num_rows];

    logic [`IFU_ADDR_W-1:0] next_req = `IFU_PC_RESET;  // address the next request must carry
    logic                   req_stale = 1'b0;          // open bus cycle began before a jump
    ifu_pkg::wb_m2s_t       exp_req;

    ifu_top dut0 (
        .clk        (clk),
        .reset_i    (reset),
        .redirect_i (redirect),
        .hold_i     (hold),
        .wb_i       (wb_rsp),
        .wb_o       (wb_req),
        .if_id_o    (if_id)
    );

    ifu_imem_model u_imem (
        .clk     (clk),
        .reset_i (reset),
        .wb_i    (wb_req),
        .wb_o    (wb_rsp)
    );

    initial begin
        forever #clk_half clk = ~clk;
    end

    // expected word at an address, the memory rule
    function automatic ifu_pkg::if_id_t fetched(input logic [`IFU_ADDR_W-1:0] addr);
        ifu_pkg::if_id_t w;
        w.valid     = 1'b1;
        w.inst      = addr ^ data_key;
        w.inst_addr = addr;
        return w;
    endfunction

    // one-line views for error lines
    function automatic string if_id_text(input ifu_pkg::if_id_t w);
        return $sformatf("valid=%b inst=%h addr=%h", w.valid, w.inst, w.inst_addr);
    endfunction

    function automatic string wb_req_text(input ifu_pkg::wb_m2s_t w);
        return $sformatf("cyc=%b stb=%b we=%b adr=%h sel=%b",
                         w.cyc, w.stb, w.we, w.adr, w.sel);
    endfunction

    task automatic abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_if_id(input string name, input ifu_pkg::if_id_t got,
                               input ifu_pkg::if_id_t exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s got %s expected %s", $time, name,
                     if_id_text(got), if_id_text(exp));
            abort_run();
        end
    endtask

    task automatic check_wb(input string name, input ifu_pkg::wb_m2s_t got,
                            input ifu_pkg::wb_m2s_t exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s got %s expected %s", $time, name,
                     wb_req_text(got), wb_req_text(exp));
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #drive_dly;  // sample outputs, then drive
    endtask

    task automatic wait_valid();
        int cycles;
        cycles = 0;
        while (!if_id.valid && cycles < wait_limit) begin
            next_cycle();
            cycles++;
        end
        if (!if_id.valid) begin
            $display("timeout: no valid instruction on if_id_o after %0d cycles", wait_limit);
            abort_run();
        end
    endtask

    // one-cycle redirect, if/id must be empty after the edge
    task automatic send_jump(input logic [`IFU_ADDR_W-1:0] target);
        redirect.valid = 1'b1;
        redirect.addr  = target;
        next_cycle();
        redirect.valid = 1'b0;
        check_bit("if_id_o.valid", if_id.valid, 1'b0);
    endtask

    task automatic fill_table();
        rows[0]  = '{ACT_RUN,       16'd4, 32'h0,         32'h0000_1000};
        rows[1]  = '{ACT_HOLD,      16'd5, 32'h0,         32'h0000_1010};
        rows[2]  = '{ACT_RUN,       16'd3, 32'h0,         32'h0000_1014};
        rows[3]  = '{ACT_JUMP,      16'd0, 32'h0000_2000, 32'h0000_2000};
        rows[4]  = '{ACT_RUN,       16'd4, 32'h0,         32'h0000_2000};
        rows[5]  = '{ACT_HOLD_JUMP, 16'd3, 32'h0000_3100, 32'h0000_2010};
        rows[6]  = '{ACT_RUN,       16'd3, 32'h0,         32'h0000_3100};
        rows[7]  = '{ACT_JUMP,      16'd0, 32'h0000_4000, 32'h0000_4000};
        rows[8]  = '{ACT_HOLD,      16'd2, 32'h0,         32'h0000_4000};
        rows[9]  = '{ACT_RUN,       16'd5, 32'h0,         32'h0000_4004};
        rows[10] = '{ACT_JUMP,      16'd0, 32'h0000_1000, 32'h0000_1000};
        rows[11] = '{ACT_RUN,       16'd2, 32'h0,         32'h0000_1000};
    endtask

    task automatic apply_row(input row_t row);
        ifu_pkg::if_id_t        held;
        logic [`IFU_ADDR_W-1:0] addr;
        addr = row.exp_addr;
        case (row.act)
            ACT_RUN: begin
                hold = 1'b0;
                repeat (row.count) begin
                    wait_valid();
                    check_if_id("if_id_o", if_id, fetched(addr));
                    addr = addr + 32'd4;
                    next_cycle();  // decode takes it on this edge
                end
            end
            ACT_HOLD, ACT_HOLD_JUMP: begin
                hold = 1'b1;
                wait_valid();  // empty if/id still loads under hold
                check_if_id("if_id_o", if_id, fetched(addr));
                held = if_id;
                repeat (row.count) begin
                    next_cycle();
                    check_if_id("if_id_o", if_id, held);
                end
                if (row.act == ACT_HOLD_JUMP) begin
                    send_jump(row.addr);  // jump beats hold
                    hold = 1'b0;
                end else begin
                    hold = 1'b0;
                    next_cycle();  // held word leaves
                end
            end
            ACT_JUMP: begin
                send_jump(row.addr);
                wait_valid();
                check_if_id("if_id_o", if_id, fetched(addr));  // left for the next row
            end
        endcase
    endtask

    // bus monitor on the falling edge, clear of the drive point
    // expected address steps by 4 per acked word, jump target after a redirect
    always @(negedge clk) begin
        if (reset) begin
            next_req  = `IFU_PC_RESET;
            req_stale = 1'b0;
        end else begin
            if (wb_req.stb && !req_stale) begin
                exp_req.cyc = 1'b1;
                exp_req.stb = 1'b1;
                exp_req.we  = 1'b0;
                exp_req.adr = next_req;
                exp_req.sel = '1;
                check_wb("wb_o", wb_req, exp_req);
            end
            if (wb_req.stb && wb_rsp.ack) begin
                if (!req_stale) begin
                    next_req = next_req + 32'd4;  // following word
                end
                req_stale = 1'b0;
            end
            if (redirect.valid) begin
                next_req  = redirect.addr;               // new stream
                req_stale = wb_req.stb && !wb_rsp.ack;  // old cycle still open
            end
        end
    end

    initial begin
        hold     = 1'b0;
        redirect = '0;
        fill_table();
        // 8 reset cycles, bus and if/id idle throughout
        repeat (8) begin
            next_cycle();
            check_bit("wb_o.cyc", wb_req.cyc, 1'b0);
            check_bit("wb_o.stb", wb_req.stb, 1'b0);
            check_bit("if_id_o.valid", if_id.valid, 1'b0);
        end
        reset = 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            apply_row(rows[i]);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
rtl/ifu_pkg.sv
rtl/ifu_pipe.sv
rtl/ifu_ifetch.sv
rtl/ifu_wb_fetch.sv
rtl/ifu_top.sv
test/ifu_imem_model.sv
test/ifu_checker.sv
test/ifu_tb.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = ifu_tb
FILELIST   = tb.f
OBJ_DIR    = obj_dir
SIM        = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
